// File: Bender.yml
package:
  name: iop_gpio

sources:
  - include_dirs:
      - hw
    files:
      - hw/iop_pkg.sv
      - hw/iop_interconnect.sv
      - hw/gpio_sample_timer.sv
      - hw/gpio_bank.sv
      - hw/iop_gpio_subsys.sv
      - target: test
        files:
          - tests/tb_clk_gen.sv
          - tests/tb_iop_gpio.sv

// File: hw/gpio_bank.sv
//----------------------------------------------------------------------
// GPIO bank: output and enable registers, pin sampling, rising edge
// detect and write-one-to-clear interrupt status
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "iop_macros.svh"

module gpio_bank
   import iop_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  iop_req_t               req,
   // This bank's select bit from the interconnect
   input  logic                   sel,
   input  logic                   sample_tick,
   input  logic [`IOP_GPIO_W-1:0] gpio_in,
   output logic [`IOP_GPIO_W-1:0] gpio_out,
   output logic [`IOP_GPIO_W-1:0] gpio_oen,
   output logic                   irq,
   output logic [31:0]            bank_rdata
);

   localparam int W = `IOP_GPIO_W;

   //-------------------------------------------------------------------
   // Register state
   //-------------------------------------------------------------------

   // Output data and output enable
   logic [W-1:0] dout;
   logic [W-1:0] oen;

   // Last pin sample, also the reference for edge detect
   logic [W-1:0] din;

   // Interrupt enable and sticky status
   logic [W-1:0] irq_en;
   logic [W-1:0] irq_stat;

   //-------------------------------------------------------------------
   // Access decode
   //-------------------------------------------------------------------

   // Word offset within the bank
   gpio_reg_e reg_sel;

   // Write strobe for this bank
   logic wr_en;

   // Rising edges seen at this tick, before enable masking
   logic [W-1:0] rise;

   // Status bits to set and to clear this cycle
   logic [W-1:0] stat_set;
   logic [W-1:0] stat_clr;

   // Register value before zero extension
   logic [W-1:0] rd_val;

   assign reg_sel = gpio_reg_e'(req.addr[4:2]);

   // Takes effect at the edge that samples the request
   assign wr_en = req.trans & req.write & sel;

   //-------------------------------------------------------------------
   // Writable registers
   //-------------------------------------------------------------------

   // DIN and IRQ_STAT are not reachable from this block
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dout   <= '0;
         oen    <= '0;
         irq_en <= '0;
      end else if (wr_en) begin
         case (reg_sel)
            REG_DOUT:   dout   <= req.wdata[W-1:0];
            REG_OEN:    oen    <= req.wdata[W-1:0];
            REG_IRQ_EN: irq_en <= req.wdata[W-1:0];
            // Read-only and unused offsets drop the write
            default: ;
         endcase
      end
   end

   assign gpio_out = dout;
   assign gpio_oen = oen;

   //-------------------------------------------------------------------
   // Pin sampling
   //-------------------------------------------------------------------

   // Pins are only looked at on the shared tick
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         din <= '0;
      end else if (sample_tick) begin
         din <= gpio_in;
      end
   end

   //-------------------------------------------------------------------
   // Edge interrupts
   //-------------------------------------------------------------------

   // New sample high, previous sample low
   assign rise = {W{sample_tick}} & gpio_in & ~din;

   // Only enabled edges reach the status
   assign stat_set = rise & irq_en;

   // Write one to clear
   assign stat_clr = (wr_en && reg_sel == REG_IRQ_STAT) ? req.wdata[W-1:0] : '0;

   // Set is applied after clear, so a set wins on the same bit
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         irq_stat <= '0;
      end else begin
         irq_stat <= (irq_stat & ~stat_clr) | stat_set;
      end
   end

   // Any pending status bit raises the bank interrupt
   assign irq = |irq_stat;

   //-------------------------------------------------------------------
   // Read data
   //-------------------------------------------------------------------

   // Lookup with no side effect
   always_comb begin
      case (reg_sel)
         REG_DOUT:     rd_val = dout;
         REG_OEN:      rd_val = oen;
         REG_DIN:      rd_val = din;
         REG_IRQ_EN:   rd_val = irq_en;
         REG_IRQ_STAT: rd_val = irq_stat;
         default:      rd_val = '0;
      endcase
   end

   // Upper bits of the word read zero
   assign bank_rdata = {{(32 - W){1'b0}}, rd_val};

   // A status bit may only rise if its enable was on at the tick
   assert property (@(posedge clk) disable iff (!rst_n)
      ((irq_stat & ~$past(irq_stat) & ~$past(irq_en)) == '0))
      else $error("gpio_bank: status bit set while its enable was off");

endmodule

// File: hw/gpio_sample_timer.sv
//----------------------------------------------------------------------
// Pin sample timer: free-running prescale counter with a one-cycle
// sample tick shared by all GPIO banks
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "iop_macros.svh"

module gpio_sample_timer (
   input  logic clk,
   input  logic rst_n,
   output logic sample_tick
);

   // Counter wide enough for the divider, at least one bit
   localparam int CNT_W = (`IOP_SAMPLE_DIV > 1) ? $clog2(`IOP_SAMPLE_DIV) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`IOP_SAMPLE_DIV - 1);

   logic [CNT_W-1:0] cnt;

   //-------------------------------------------------------------------
   // Prescale counter
   //-------------------------------------------------------------------

   // Wraps every IOP_SAMPLE_DIV cycles, starting from zero after reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (cnt == CNT_LAST) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // Tick on the last count, so the first one lands on cycle DIV
   // One instant for all banks keeps their pin samples aligned
   assign sample_tick = (cnt == CNT_LAST);

   // Banks rely on a single-cycle pulse for their edge detect
   assert property (@(posedge clk) disable iff (!rst_n) sample_tick |=> !sample_tick)
      else $error("gpio_sample_timer: tick high on consecutive cycles");

endmodule

// File: hw/iop_gpio_subsys.sv
//----------------------------------------------------------------------
// IOP GPIO subsystem top: interconnect, sample timer and three banks
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "iop_macros.svh"

module iop_gpio_subsys
   import iop_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // Requester side
   input  iop_req_t               req,
   output logic [31:0]            rdata,
   output logic                   match,
   // Bank 0 pins
   input  logic [`IOP_GPIO_W-1:0] gpio_in_0,
   output logic [`IOP_GPIO_W-1:0] gpio_out_0,
   output logic [`IOP_GPIO_W-1:0] gpio_oen_0,
   // Bank 1 pins
   input  logic [`IOP_GPIO_W-1:0] gpio_in_1,
   output logic [`IOP_GPIO_W-1:0] gpio_out_1,
   output logic [`IOP_GPIO_W-1:0] gpio_oen_1,
   // Bank 2 pins
   input  logic [`IOP_GPIO_W-1:0] gpio_in_2,
   output logic [`IOP_GPIO_W-1:0] gpio_out_2,
   output logic [`IOP_GPIO_W-1:0] gpio_oen_2,
   // One interrupt per bank
   output logic [2:0]             irq
);

   // Bank selects from the decode
   iop_sel_t sel;

   // Per-bank read data into the mux
   logic [31:0] bank_rdata0;
   logic [31:0] bank_rdata1;
   logic [31:0] bank_rdata2;

   // Shared pin sample strobe
   logic sample_tick;

   //-------------------------------------------------------------------
   // Decode and read mux
   //-------------------------------------------------------------------

   iop_interconnect i_interconnect (
      .req        (req),
      .bank_rdata0(bank_rdata0),
      .bank_rdata1(bank_rdata1),
      .bank_rdata2(bank_rdata2),
      .sel        (sel),
      .match      (match),
      .rdata      (rdata)
   );

   gpio_sample_timer i_timer (
      .clk        (clk),
      .rst_n      (rst_n),
      .sample_tick(sample_tick)
   );

   //-------------------------------------------------------------------
   // GPIO banks
   //-------------------------------------------------------------------

   gpio_bank i_bank0 (
      .clk(clk), .rst_n(rst_n), .req(req), .sel(sel.gpio0), .sample_tick(sample_tick),
      .gpio_in(gpio_in_0), .gpio_out(gpio_out_0), .gpio_oen(gpio_oen_0),
      .irq(irq[0]), .bank_rdata(bank_rdata0)
   );

   gpio_bank i_bank1 (
      .clk(clk), .rst_n(rst_n), .req(req), .sel(sel.gpio1), .sample_tick(sample_tick),
      .gpio_in(gpio_in_1), .gpio_out(gpio_out_1), .gpio_oen(gpio_oen_1),
      .irq(irq[1]), .bank_rdata(bank_rdata1)
   );

   gpio_bank i_bank2 (
      .clk(clk), .rst_n(rst_n), .req(req), .sel(sel.gpio2), .sample_tick(sample_tick),
      .gpio_in(gpio_in_2), .gpio_out(gpio_out_2), .gpio_oen(gpio_oen_2),
      .irq(irq[2]), .bank_rdata(bank_rdata2)
   );

endmodule

// File: hw/iop_interconnect.sv
//----------------------------------------------------------------------
// IOP interconnect: address match query, bank select decode and
// read data multiplexer for three GPIO banks
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "iop_macros.svh"

module iop_interconnect
   import iop_pkg::*;
(
   input  iop_req_t    req,
   input  logic [31:0] bank_rdata0,
   input  logic [31:0] bank_rdata1,
   input  logic [31:0] bank_rdata2,
   output iop_sel_t    sel,
   output logic        match,
   output logic [31:0] rdata
);

   // Base addresses as vectors so the decode bits can be sliced
   localparam logic [31:0] BASE0 = `IOP_BASE_GPIO0;
   localparam logic [31:0] BASE1 = `IOP_BASE_GPIO1;
   localparam logic [31:0] BASE2 = `IOP_BASE_GPIO2;

   // Per-bank hit on the query address
   logic [2:0] check_hit;

   //-------------------------------------------------------------------
   // Match query
   //-------------------------------------------------------------------

   // Only bits above the bank window take part
   assign check_hit[0] = (req.check[31:`IOP_DEC_LSB] == BASE0[31:`IOP_DEC_LSB]);
   assign check_hit[1] = (req.check[31:`IOP_DEC_LSB] == BASE1[31:`IOP_DEC_LSB]);
   assign check_hit[2] = (req.check[31:`IOP_DEC_LSB] == BASE2[31:`IOP_DEC_LSB]);

   // Answer does not depend on trans
   assign match = |check_hit;

   //-------------------------------------------------------------------
   // Access decode
   //-------------------------------------------------------------------

   // Selects follow addr alone, the banks gate writes with trans
   assign sel.gpio0 = (req.addr[31:`IOP_DEC_LSB] == BASE0[31:`IOP_DEC_LSB]);
   assign sel.gpio1 = (req.addr[31:`IOP_DEC_LSB] == BASE1[31:`IOP_DEC_LSB]);
   assign sel.gpio2 = (req.addr[31:`IOP_DEC_LSB] == BASE2[31:`IOP_DEC_LSB]);

   // AND-OR read mux, zero when nothing is selected
   assign rdata = ({32{sel.gpio0}} & bank_rdata0) |
                  ({32{sel.gpio1}} & bank_rdata1) |
                  ({32{sel.gpio2}} & bank_rdata2);

   // Overlapping bases would OR two banks onto rdata
   always_comb begin
      assert final ($onehot0(sel))
         else $error("iop_interconnect: more than one bank selected");
   end

endmodule

// File: hw/iop_macros.svh
//----------------------------------------------------------------------
// IOP GPIO subsystem constants: bank base addresses, decode boundary,
// pins per bank and pin sample divider
//----------------------------------------------------------------------

`ifndef IOP_MACROS_SVH
`define IOP_MACROS_SVH

//----------------------------------------------------------------------
// Address map
//----------------------------------------------------------------------

// Bank bases, each on a 2 KB boundary
`define IOP_BASE_GPIO0 32'h4000_0000
`define IOP_BASE_GPIO1 32'h4000_0800
`define IOP_BASE_GPIO2 32'h4000_1000

// Lowest address bit compared in the bank decode
`define IOP_DEC_LSB 11

//----------------------------------------------------------------------
// Bank geometry and sampling
//----------------------------------------------------------------------

// Pins per bank
`define IOP_GPIO_W 16

// Cycles between pin sample ticks
`define IOP_SAMPLE_DIV 4

`endif

// File: hw/iop_pkg.sv
//----------------------------------------------------------------------
// IOP GPIO types: request struct, bank select struct and register
// offset enum
//----------------------------------------------------------------------

package iop_pkg;

   //-------------------------------------------------------------------
   // IOP request, one transfer per cycle
   //-------------------------------------------------------------------
   typedef struct packed {
      // Transfer valid strobe
      logic        trans;
      // High for a write, low for a read
      logic        write;
      // Access address
      logic [31:0] addr;
      // Match query address, looked up independently of trans
      logic [31:0] check;
      // Write data, whole word only
      logic [31:0] wdata;
   } iop_req_t;

   // One select bit per GPIO bank
   typedef struct packed {
      logic gpio2;
      logic gpio1;
      logic gpio0;
   } iop_sel_t;

   // Register word offsets, taken from addr[4:2]
   // Offsets 5 to 7 read zero and drop writes
   typedef enum logic [2:0] {
      REG_DOUT     = 3'd0,
      REG_OEN      = 3'd1,
      REG_DIN      = 3'd2,
      REG_IRQ_EN   = 3'd3,
      REG_IRQ_STAT = 3'd4
   } gpio_reg_e;

endpackage

// File: tb.f
+incdir+hw
hw/iop_pkg.sv
hw/iop_interconnect.sv
hw/gpio_sample_timer.sv
hw/gpio_bank.sv
hw/iop_gpio_subsys.sv
tests/tb_clk_gen.sv
tests/tb_iop_gpio.sv

// File: tests/tb_clk_gen.sv
//----------------------------------------------------------------------
// Testbench clock and synchronous reset generator
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD     = 8,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   // Free-running clock, 8 ns period
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset low for the first cycles, released just after an edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

// File: tests/tb_iop_gpio.sv
//----------------------------------------------------------------------
// IOP GPIO subsystem testbench: random stimulus, reference model of
// all bank registers and the sample timer, checks and final report
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "iop_macros.svh"

module tb_iop_gpio
   import iop_pkg::*;
();

   localparam int W           = `IOP_GPIO_W;
   localparam int DIV         = `IOP_SAMPLE_DIV;
   // Drive point and check point within a cycle
   localparam int DRV_DLY     = 2;
   localparam int CHK_DLY     = 4;
   localparam int RST_TIMEOUT = 20;
   localparam int TICK_TIMEOUT = 2 * DIV;
   localparam int IRQ_TIMEOUT = 64;

   logic                clk;
   logic                rst_n;
   iop_req_t            req;
   logic [31:0]         rdata;
   logic                match;
   logic [2:0][W-1:0]   pins;
   logic [2:0][W-1:0]   gpio_out;
   logic [2:0][W-1:0]   gpio_oen;
   logic [2:0]          irq;

   //-------------------------------------------------------------------
   // Reference model state
   //-------------------------------------------------------------------
   logic [W-1:0] m_dout [3];
   logic [W-1:0] m_oen  [3];
   logic [W-1:0] m_din  [3];
   logic [W-1:0] m_en   [3];
   logic [W-1:0] m_stat [3];
   // Cycle number since reset release, first cycle is 1
   int           cyc;

   integer       seed;
   int           errors;
   int           timeouts;
   // rdata seen at the last check point
   logic [31:0]  last_rdata;

   tb_clk_gen #(.PERIOD(8), .RST_CYCLES(4)) i_clk_gen (.clk(clk), .rst_n(rst_n));

   iop_gpio_subsys i_dut (
      .clk(clk), .rst_n(rst_n), .req(req), .rdata(rdata), .match(match),
      .gpio_in_0(pins[0]), .gpio_out_0(gpio_out[0]), .gpio_oen_0(gpio_oen[0]),
      .gpio_in_1(pins[1]), .gpio_out_1(gpio_out[1]), .gpio_oen_1(gpio_oen[1]),
      .gpio_in_2(pins[2]), .gpio_out_2(gpio_out[2]), .gpio_oen_2(gpio_oen[2]),
      .irq(irq)
   );

   //-------------------------------------------------------------------
   // Address map helpers
   //-------------------------------------------------------------------
   function automatic logic [31:0] base_of(input int b);
      case (b)
         0:       return `IOP_BASE_GPIO0;
         1:       return `IOP_BASE_GPIO1;
         default: return `IOP_BASE_GPIO2;
      endcase
   endfunction

   // Bank hit on the bits above the 2 KB window, -1 when unmapped
   function automatic int bank_of(input logic [31:0] a);
      logic [31:0] base;
      for (int b = 0; b < 3; b++) begin
         base = base_of(b);
         if (a[31:`IOP_DEC_LSB] == base[31:`IOP_DEC_LSB]) return b;
      end
      return -1;
   endfunction

   // Expected read word, zero for unmapped addresses and offsets 5 to 7
   function automatic logic [31:0] exp_rdata(input logic [31:0] a);
      int b;
      b = bank_of(a);
      if (b < 0) return 32'h0;
      case (a[4:2])
         3'd0:    return {16'h0, m_dout[b]};
         3'd1:    return {16'h0, m_oen[b]};
         3'd2:    return {16'h0, m_din[b]};
         3'd3:    return {16'h0, m_en[b]};
         3'd4:    return {16'h0, m_stat[b]};
         default: return 32'h0;
      endcase
   endfunction

   function automatic iop_req_t make_req(input logic trans, input logic write,
                                         input logic [31:0] addr, input logic [31:0] check,
                                         input logic [31:0] wdata);
      iop_req_t r;
      r.trans = trans;
      r.write = write;
      r.addr  = addr;
      r.check = check;
      r.wdata = wdata;
      return r;
   endfunction

   // Biased toward the bases, their register offsets and the neighbours
   function automatic logic [31:0] rand_addr();
      int          kind;
      logic [31:0] base;
      base = base_of({$random(seed)} % 3);
      kind = {$random(seed)} % 8;
      case (kind)
         0, 1, 2, 3: return base + ({$random(seed)} % 8) * 4;
         4:          return base + ({$random(seed)} & 32'h7FF);
         5:          return base - 32'd4;
         6:          return base + 32'h800 + ({$random(seed)} % 8) * 4;
         default:    return $random(seed);
      endcase
   endfunction

   //-------------------------------------------------------------------
   // Checks
   //-------------------------------------------------------------------
   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_outputs();
      last_rdata = rdata;
      compare(match, bank_of(req.check) >= 0, "match");
      compare(rdata, exp_rdata(req.addr), "rdata");
      compare(i_dut.sample_tick, (cyc % DIV) == 0, "sample tick");
      for (int b = 0; b < 3; b++) begin
         compare(irq[b], |m_stat[b], $sformatf("bank %0d irq", b));
         compare(gpio_out[b], m_dout[b], $sformatf("bank %0d gpio_out", b));
         compare(gpio_oen[b], m_oen[b], $sformatf("bank %0d gpio_oen", b));
      end
   endtask

   // Next model state from the inputs held at the rising edge
   task automatic update_model();
      logic [W-1:0] set_bits;
      logic [W-1:0] clr_bits;
      logic         tick;
      logic         wr;
      tick = (cyc % DIV) == 0;
      for (int b = 0; b < 3; b++) begin
         wr       = req.trans && req.write && (bank_of(req.addr) == b);
         // Uses the previous sample and the enable before any write
         set_bits = tick ? (pins[b] & ~m_din[b] & m_en[b]) : '0;
         clr_bits = (wr && req.addr[4:2] == 3'd4) ? req.wdata[W-1:0] : '0;
         // Set wins over clear on the same bit
         m_stat[b] = (m_stat[b] & ~clr_bits) | set_bits;
         if (tick) m_din[b] = pins[b];
         if (wr) begin
            case (req.addr[4:2])
               3'd0:    m_dout[b] = req.wdata[W-1:0];
               3'd1:    m_oen[b]  = req.wdata[W-1:0];
               3'd3:    m_en[b]   = req.wdata[W-1:0];
               default: ;
            endcase
         end
      end
      cyc++;
   endtask

   //-------------------------------------------------------------------
   // Stimulus
   //-------------------------------------------------------------------

   // Entered at the drive point, left at the next drive point
   task automatic drive_cycle(input iop_req_t r);
      req = r;
      #(CHK_DLY);
      check_outputs();
      @(posedge clk);
      update_model();
      #(DRV_DLY);
   endtask

   task automatic idle_cycle();
      drive_cycle(make_req({$random(seed)} % 2, 1'b0, rand_addr(), rand_addr(), $random(seed)));
   endtask

   task automatic read_reg(input int b, input int off);
      drive_cycle(make_req(1'b1, 1'b0, base_of(b) + off * 4, rand_addr(), 32'h0));
   endtask

   task automatic write_reg(input int b, input int off, input logic [31:0] data);
      drive_cycle(make_req(1'b1, 1'b1, base_of(b) + off * 4, rand_addr(), data));
   endtask

   // Stops at the drive point of a cycle whose tick is high
   task automatic wait_tick();
      int n;
      n = 0;
      while (i_dut.sample_tick !== 1'b1) begin
         if (n >= TICK_TIMEOUT) begin
            $display("timeout: no sample tick within %0d cycles", n);
            timeouts++;
            return;
         end
         idle_cycle();
         n++;
      end
   endtask

   task automatic wait_irq(input int b);
      int n;
      n = 0;
      while (irq[b] !== 1'b1) begin
         if (n >= IRQ_TIMEOUT) begin
            $display("timeout: bank %0d interrupt never raised in %0d cycles", b, n);
            timeouts++;
            return;
         end
         pins[b] = $random(seed);
         idle_cycle();
         n++;
      end
   endtask

   //-------------------------------------------------------------------
   // Test phases
   //-------------------------------------------------------------------

   // Every register of every bank reads zero after reset
   task automatic reset_phase();
      for (int b = 0; b < 3; b++) begin
         for (int off = 0; off < 5; off++) begin
            read_reg(b, off);
            compare(last_rdata, 32'h0, $sformatf("bank %0d offset %0d after reset", b, off));
         end
      end
   endtask

   task automatic register_phase();
      int          b;
      int          off;
      logic [31:0] addr;
      repeat (200) begin
         b    = {$random(seed)} % 3;
         off  = {$random(seed)} % 8;
         addr = base_of(b) + off * 4;
         // Some writes go out without trans and must be dropped
         drive_cycle(make_req(({$random(seed)} % 8) != 0, 1'b1, addr, rand_addr(),
                              $random(seed)));
         drive_cycle(make_req(1'b1, 1'b0, addr, addr, 32'h0));
      end
   endtask

   task automatic sampling_phase();
      logic [2:0][W-1:0] sampled;
      repeat (20) begin
         for (int b = 0; b < 3; b++) pins[b] = $random(seed);
         wait_tick();
         sampled = pins;
         idle_cycle();
         for (int b = 0; b < 3; b++) begin
            read_reg(b, 2);
            compare(last_rdata, {16'h0, sampled[b]}, $sformatf("bank %0d DIN", b));
         end
      end
   endtask

   task automatic edge_phase();
      int b;
      for (b = 0; b < 3; b++) write_reg(b, 3, $random(seed) | 32'h1);
      for (b = 0; b < 3; b++) write_reg(b, 4, 32'hFFFF);
      for (b = 0; b < 3; b++) wait_irq(b);
      repeat (150) begin
         pins ^= {$random(seed), $random(seed)};
         b = {$random(seed)} % 3;
         read_reg(b, 4);
         // Bits with the enable off never show up in the status
         compare(last_rdata & {16'h0, ~m_en[b]}, 32'h0, $sformatf("bank %0d disabled bits", b));
      end
   endtask

   task automatic clear_phase();
      int          b;
      logic [31:0] mask;
      repeat (150) begin
         pins ^= {$random(seed), $random(seed)};
         b    = {$random(seed)} % 3;
         // On tick cycles clear everything so a new set collides with it
         mask = ((cyc % DIV) == 0) ? 32'hFFFF : $random(seed);
         write_reg(b, 4, mask);
         if (({$random(seed)} % 2) == 0) read_reg(b, 4);
      end
   endtask

   //-------------------------------------------------------------------
   // Main sequence
   //-------------------------------------------------------------------
   initial begin
      int n;
      seed     = 32'hb887;
      errors   = 0;
      timeouts = 0;
      cyc      = 1;
      req      = '0;
      pins     = '0;
      for (int b = 0; b < 3; b++) begin
         m_dout[b] = '0;
         m_oen[b]  = '0;
         m_din[b]  = '0;
         m_en[b]   = '0;
         m_stat[b] = '0;
      end

      n = 0;
      while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
         @(posedge clk);
         #(DRV_DLY);
         n++;
      end

      if (rst_n !== 1'b1) begin
         $display("timeout: reset was never released");
         timeouts++;
      end else begin
         reset_phase();
         register_phase();
         // Decode sweep with distinct nonzero registers behind every bank
         for (int k = 0; k < 300; k++) idle_cycle();
         sampling_phase();
         edge_phase();
         clear_phase();
      end

      $display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
